// ==== logic/rvga_params.svh ====
`ifndef RVGA_PARAMS_SVH
`define RVGA_PARAMS_SVH

// geometry of one cacheline in bytes, a power of two and a multiple of 4
`define RVGA_LINE_BYTES 32

// depth of the backing store in lines, 512 lines of 32 bytes is 16 KiB
`define RVGA_MEM_LINES 512

// wait cycles before the line memory answers
// zero gives the single-cycle fast path
`define RVGA_MEM_LATENCY 4

`endif

// ==== logic/rvga_types_pkg.sv ====
`include "rvga_params.svh"

package rvga_types_pkg;

  typedef logic [31:0] rvga_word;
  typedef logic [7:0] rvga_byte;
  typedef logic [3:0] rvga_sel;  // one bit per byte lane of a word

  typedef logic [`RVGA_LINE_BYTES*8-1:0] rvga_cacheline;

  localparam int LINE_OFS_BITS = $clog2(`RVGA_LINE_BYTES);  // byte offset inside a line
  localparam int WORDS_PER_LINE = `RVGA_LINE_BYTES / 4;

  // word address with the line offset stripped off
  typedef logic [$bits(rvga_word)-LINE_OFS_BITS-1:0] rvga_line_addr;

endpackage : rvga_types_pkg

// ==== logic/rvga_bus_pkg.sv ====
package rvga_bus_pkg;

  import rvga_types_pkg::*;

  // request from the bus port into the line buffer
  typedef struct packed {
    logic valid;
    logic we;
    rvga_word addr;
    rvga_word wdata;
    rvga_sel sel;
  } word_req_t;

  typedef struct packed {
    logic done;  // one-cycle pulse, rdata valid with it
    rvga_word rdata;
  } word_rsp_t;

  // held-request bus between the line buffer and the line memory
  typedef struct packed {
    logic read;
    logic write;
    rvga_line_addr addr;
    rvga_cacheline wdata;
  } membus_req_t;

  typedef struct packed {
    logic resp;
    rvga_cacheline rdata;
  } membus_rsp_t;

  typedef enum logic [1:0] {
    BUF_IDLE,
    BUF_WRITEBACK,  // dirty line going out before the refill
    BUF_FILL,
    BUF_SERVE
  } buf_state_e;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_BUSY,
    MEM_RESPOND
  } mem_state_e;

endpackage : rvga_bus_pkg

// ==== logic/wb_word_port.sv ====
`timescale 1ns/1ps

module wb_word_port (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  rvga_types_pkg::rvga_word wb_adr_i,
  input  rvga_types_pkg::rvga_word wb_dat_i,
  input  rvga_types_pkg::rvga_sel  wb_sel_i,
  input  rvga_bus_pkg::word_rsp_t  rsp_i,
  output rvga_types_pkg::rvga_word wb_dat_o,
  output logic                     wb_ack_o,
  output rvga_bus_pkg::word_req_t  req_o
);

  import rvga_types_pkg::*;
  import rvga_bus_pkg::*;

  logic ack_q;
  rvga_word dat_q;
  word_req_t cap_q;  // valid doubles as the pending flag until done returns
  logic capture;
  logic finish;

  // the master still holds stb during the ack cycle, so no capture then
  assign capture = wb_cyc_i && wb_stb_i && !cap_q.valid && !ack_q;
  assign finish = cap_q.valid && rsp_i.done;

  always_ff @(posedge clk) begin
    if (rst) begin
      cap_q.valid <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= finish;  // ack lasts exactly one cycle
      if (capture) begin
        cap_q <= '{valid: 1'b1,
                   we: wb_we_i,
                   addr: wb_adr_i,
                   wdata: wb_dat_i,
                   sel: wb_sel_i};
      end else if (finish) begin
        cap_q.valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (finish) begin
      dat_q <= rsp_i.rdata;
    end
  end

  assign req_o = cap_q;
  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

endmodule : wb_word_port

// ==== logic/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
  input  logic                      clk,
  input  logic                      rst,
  input  rvga_bus_pkg::word_req_t   req_i,
  input  rvga_bus_pkg::membus_rsp_t mem_rsp_i,
  output rvga_bus_pkg::word_rsp_t   rsp_o,
  output rvga_bus_pkg::membus_req_t mem_req_o
);

  import rvga_types_pkg::*;
  import rvga_bus_pkg::*;

  localparam int IDX_W = $clog2(WORDS_PER_LINE);

  buf_state_e state_q;
  logic valid_q;
  logic dirty_q;
  logic done_q;
  logic mem_read_q;
  logic mem_write_q;

  rvga_cacheline line_q;
  rvga_line_addr tag_q;
  rvga_line_addr mem_addr_q;
  rvga_word rdata_q;

  rvga_line_addr req_line;
  logic [IDX_W-1:0] word_idx;
  logic new_req;
  logic hit;
  logic access;
  logic miss_start;
  logic evict;
  rvga_word rd_word;
  rvga_cacheline merged_line;

  assign req_line = req_i.addr[$bits(rvga_word)-1:LINE_OFS_BITS];
  assign word_idx = req_i.addr[LINE_OFS_BITS-1:2];

  // done_q still high means the port has not yet dropped this request
  assign new_req = (state_q == BUF_IDLE) && req_i.valid && !done_q;
  assign hit = valid_q && (tag_q == req_line);
  assign access = (new_req && hit) || (state_q == BUF_SERVE);
  assign miss_start = new_req && !hit;
  assign evict = valid_q && dirty_q;

  always_comb begin
    rd_word = line_q[word_idx*32 +: 32];
    merged_line = line_q;
    for (int b = 0; b < 4; b++) begin
      if (req_i.sel[b]) begin
        merged_line[word_idx*32 + b*8 +: 8] = req_i.wdata[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= BUF_IDLE;
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
      done_q <= 1'b0;
      mem_read_q <= 1'b0;
      mem_write_q <= 1'b0;
    end else begin
      done_q <= access;
      if (access && req_i.we) begin
        dirty_q <= 1'b1;
      end
      case (state_q)
        BUF_IDLE: begin
          if (miss_start) begin
            if (evict) begin
              mem_write_q <= 1'b1;
              state_q <= BUF_WRITEBACK;
            end else begin
              mem_read_q <= 1'b1;
              state_q <= BUF_FILL;
            end
          end
        end
        BUF_WRITEBACK: begin
          if (mem_rsp_i.resp) begin
            mem_write_q <= 1'b0;
            mem_read_q <= 1'b1;  // refill starts the cycle after resp
            state_q <= BUF_FILL;
          end
        end
        BUF_FILL: begin
          if (mem_rsp_i.resp) begin
            mem_read_q <= 1'b0;
            valid_q <= 1'b1;
            dirty_q <= 1'b0;
            state_q <= BUF_SERVE;
          end
        end
        BUF_SERVE: state_q <= BUF_IDLE;
        default: state_q <= BUF_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= rd_word;
      if (req_i.we) begin
        line_q <= merged_line;
      end
    end
    if ((state_q == BUF_FILL) && mem_rsp_i.resp) begin
      line_q <= mem_rsp_i.rdata;
      tag_q <= req_line;
    end
    if (miss_start) begin
      mem_addr_q <= evict ? tag_q : req_line;
    end else if ((state_q == BUF_WRITEBACK) && mem_rsp_i.resp) begin
      mem_addr_q <= req_line;
    end
  end

  // the held line is the write-back data, it stays put until the fill lands
  assign mem_req_o = '{read: mem_read_q,
                       write: mem_write_q,
                       addr: mem_addr_q,
                       wdata: line_q};

  assign rsp_o = '{done: done_q, rdata: rdata_q};

endmodule : line_buffer

// ==== logic/line_memory.sv ====
`timescale 1ns/1ps

`include "rvga_params.svh"

module line_memory (
  input  logic                      clk,
  input  logic                      rst,
  input  rvga_bus_pkg::membus_req_t req_i,
  output rvga_bus_pkg::membus_rsp_t rsp_o
);

  import rvga_types_pkg::*;
  import rvga_bus_pkg::*;

  localparam int IDX_W = $clog2(`RVGA_MEM_LINES);
  localparam int CNT_W = (`RVGA_MEM_LATENCY > 1) ? $clog2(`RVGA_MEM_LATENCY + 1) : 1;
  localparam logic [CNT_W-1:0] LAT_CNT = CNT_W'(`RVGA_MEM_LATENCY);
  localparam bit MAGIC = (`RVGA_MEM_LATENCY == 0);  // answer straight out of idle

  rvga_cacheline mem_q [`RVGA_MEM_LINES];

  mem_state_e state_q;
  logic [CNT_W-1:0] cnt_q;
  logic resp_q;
  rvga_cacheline rdata_q;

  logic [IDX_W-1:0] idx;
  logic active;
  logic fire;

  assign idx = req_i.addr[IDX_W-1:0];  // wraps modulo the depth
  assign active = req_i.read || req_i.write;

  assign fire = ((state_q == MEM_IDLE) && active && MAGIC) ||
                ((state_q == MEM_BUSY) && (cnt_q == LAT_CNT));

  // identity pattern, every word holds its own byte address
  initial begin
    for (int l = 0; l < `RVGA_MEM_LINES; l++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        mem_q[l][w*32 +: 32] = rvga_word'(l * `RVGA_LINE_BYTES + w * 4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= MEM_IDLE;
      cnt_q <= '0;
      resp_q <= 1'b0;
    end else begin
      resp_q <= fire;
      case (state_q)
        MEM_IDLE: begin
          if (active) begin
            cnt_q <= CNT_W'(1);
            state_q <= fire ? MEM_RESPOND : MEM_BUSY;
          end
        end
        MEM_BUSY: begin
          if (fire) begin
            state_q <= MEM_RESPOND;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        MEM_RESPOND: state_q <= MEM_IDLE;  // one cycle before the next request
        default: state_q <= MEM_IDLE;
      endcase
    end
  end

  always @(posedge clk) begin
    if (fire && req_i.write) begin
      mem_q[idx] <= req_i.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (fire && req_i.read) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign rsp_o = '{resp: resp_q, rdata: rdata_q};

endmodule : line_memory

// ==== logic/rvga_mem_top.sv ====
`timescale 1ns/1ps

module rvga_mem_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  rvga_types_pkg::rvga_word wb_adr_i,
  input  rvga_types_pkg::rvga_word wb_dat_i,
  input  rvga_types_pkg::rvga_sel  wb_sel_i,
  output rvga_types_pkg::rvga_word wb_dat_o,
  output logic                     wb_ack_o
);

  import rvga_bus_pkg::*;

  word_req_t word_req;
  word_rsp_t word_rsp;
  membus_req_t mem_req;
  membus_rsp_t mem_rsp;

  wb_word_port u_port (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .rsp_i    (word_rsp),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .req_o    (word_req)
  );

  line_buffer u_buffer (
    .clk       (clk),
    .rst       (rst),
    .req_i     (word_req),
    .mem_rsp_i (mem_rsp),
    .rsp_o     (word_rsp),
    .mem_req_o (mem_req)
  );

  line_memory u_memory (
    .clk   (clk),
    .rst   (rst),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

endmodule : rvga_mem_top

// ==== bench/rvga_mem_tb.sv ====
`timescale 1ns/1ps

`include "rvga_params.svh"

module rvga_mem_tb;

  import rvga_types_pkg::*;

  localparam int CLK_NS = 8;
  localparam int MEM_BYTES = `RVGA_MEM_LINES * `RVGA_LINE_BYTES;
  localparam int MEM_WORDS = MEM_BYTES / 4;
  localparam int TXN_BUDGET = 600;
  localparam int CYCLES_PER_TXN = 2 * `RVGA_MEM_LATENCY + 12;  // dirty miss plus margin
  localparam longint WATCHDOG_NS = longint'(TXN_BUDGET) * CYCLES_PER_TXN * CLK_NS;

  logic clk;
  logic rst;
  logic wb_cyc_i;
  logic wb_stb_i;
  logic wb_we_i;
  rvga_word wb_adr_i;
  rvga_word wb_dat_i;
  rvga_sel wb_sel_i;
  rvga_word wb_dat_o;
  logic wb_ack_o;

  rvga_word ref_mem [MEM_WORDS];  // expected contents of the whole store

  string name_q [$];
  rvga_word exp_q [$];
  rvga_word act_q [$];

  int errors = 0;
  int txn_count = 0;
  int ack_count = 0;

  rvga_mem_top DUT (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_NS / 2) clk = ~clk;
    end
  end

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = rvga_word'(i * 4);  // every word starts as its own byte address
    end
  end

  // applies a write with its byte selects and returns the word as it then stands
  function automatic rvga_word ref_access(input bit we, input rvga_word addr,
                                          input rvga_word data, input rvga_sel sel);
    int unsigned idx;
    rvga_word word;
    idx = (addr % MEM_BYTES) / 4;
    word = ref_mem[idx];
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          word[b*8 +: 8] = data[b*8 +: 8];
        end
      end
      ref_mem[idx] = word;
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // one Wishbone classic cycle, entered and left just after a falling edge
  task automatic bus_xfer(input string name, input bit we, input rvga_word addr,
                          input rvga_word data, input rvga_sel sel, output int cycles);
    rvga_word expected;
    expected = ref_access(we, addr, data, sel);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i = we;
    wb_adr_i = addr;
    wb_dat_i = data;
    wb_sel_i = sel;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!wb_ack_o);
    txn_count++;
    if (!we) begin
      name_q.push_back(name);
      exp_q.push_back(expected);
      act_q.push_back(wb_dat_o);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    @(negedge clk);
    if (wb_ack_o) begin
      errors++;
      $display("%s: wb_ack_o stayed high for more than one cycle", name);
    end
  endtask

  always @(negedge clk) begin
    if (wb_ack_o) begin
      ack_count++;
    end
  end

  initial begin : compare
    forever begin
      @(negedge clk);
      while (exp_q.size() > 0) begin
        check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, wb_ack_o never came for a transaction",
             WATCHDOG_NS);
    $display("%0d errors in %0d transactions", errors, txn_count);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    int lat;
    int unsigned seed;
    rvga_word addr;
    seed = $urandom(41511);
    rst = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    repeat (4) begin
      @(negedge clk);
      if (wb_ack_o) begin
        errors++;
        $display("wb_ack_o went high while reset was asserted");
      end
    end
    rst = 1'b0;

    // untouched words anywhere in the store
    for (int i = 0; i < 32; i++) begin
      addr = ($urandom % MEM_WORDS) * 4;
      bus_xfer($sformatf("identity read %h", addr), 1'b0, addr, '0, 4'hf, lat);
    end

    bus_xfer("hit write fill", 1'b1, 32'h0000_1208, 32'ha5a5_0001, 4'hf, lat);
    bus_xfer("hit read merged", 1'b0, 32'h0000_1208, '0, 4'hf, lat);
    check_value("hit read latency", 3, lat);
    bus_xfer("hit read neighbour", 1'b0, 32'h0000_1200, '0, 4'hf, lat);
    check_value("hit read neighbour latency", 3, lat);
    bus_xfer("hit partial write", 1'b1, 32'h0000_120c, 32'h1234_5678, 4'b0011, lat);
    check_value("hit write latency", 3, lat);
    bus_xfer("hit read partial", 1'b0, 32'h0000_120c, '0, 4'hf, lat);
    check_value("hit read partial latency", 3, lat);

    // random sel over eight lines, so misses mix with hits
    for (int i = 0; i < 20; i++) begin
      addr = 32'h0000_0800 + ($urandom % 64) * 4;
      bus_xfer($sformatf("sel write %h", addr), 1'b1, addr, $urandom, $urandom, lat);
      bus_xfer($sformatf("sel read %h", addr), 1'b0, addr, '0, 4'hf, lat);
    end

    bus_xfer("evict write a0", 1'b1, 32'h0000_2004, 32'hdead_beef, 4'hf, lat);
    bus_xfer("evict write a1", 1'b1, 32'h0000_2014, 32'h0bad_f00d, 4'b1100, lat);
    bus_xfer("evict read b", 1'b0, 32'h0000_2804, '0, 4'hf, lat);
    bus_xfer("evict read a0", 1'b0, 32'h0000_2004, '0, 4'hf, lat);
    bus_xfer("evict read a1", 1'b0, 32'h0000_2014, '0, 4'hf, lat);
    // 0x5010 wraps onto the same memory line as 0x1010 under another tag
    bus_xfer("alias write", 1'b1, 32'h0000_1010, 32'hcafe_0042, 4'hf, lat);
    bus_xfer("alias read wrapped", 1'b0, 32'h0000_5010, '0, 4'hf, lat);
    bus_xfer("alias read back", 1'b0, 32'h0000_1010, '0, 4'hf, lat);

    for (int i = 0; i < 500; i++) begin
      addr = 32'h0000_3000 + ($urandom % 6) * `RVGA_LINE_BYTES
             + ($urandom % WORDS_PER_LINE) * 4;
      bus_xfer($sformatf("random %0d at %h", i, addr), $urandom % 2, addr,
               $urandom, $urandom, lat);
    end

    repeat (2) @(negedge clk);
    check_value("ack count", txn_count, ack_count);
    $display("%0d errors in %0d transactions", errors, txn_count);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : rvga_mem_tb

// ==== sources.f ====
+incdir+logic
logic/rvga_types_pkg.sv
logic/rvga_bus_pkg.sv
logic/wb_word_port.sv
logic/line_buffer.sv
logic/line_memory.sv
logic/rvga_mem_top.sv
bench/rvga_mem_tb.sv
